// File: hdl/ex_params.svh
// ################################################
// execute stage constants
// ################################################
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

`define XLEN        32
`define REG_ADDR_W  5
`define INST_W      32

// major opcodes
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_BRANCH  7'b1100011

`define F7_BASE     7'b0000000
`define F7_ALT      7'b0100000  // sub and sra
`define F7_MULDIV   7'b0000001

// base integer funct3
`define F3_ADD_SUB  3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SR       3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// m extension funct3
`define F3_MUL      3'b000
`define F3_MULH     3'b001
`define F3_MULHSU   3'b010
`define F3_MULHU    3'b011
`define F3_DIV      3'b100
`define F3_DIVU     3'b101
`define F3_REM      3'b110
`define F3_REMU     3'b111

// branch funct3
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101
`define F3_BLTU     3'b110
`define F3_BGEU     3'b111

`define DIV_STEPS   32  // one quotient bit per step

`endif

// File: hdl/ex_pkg.sv
// ################################################
// execute stage types
// ################################################
`include "ex_params.svh"

package ex_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [2*`XLEN-1:0]     dword_t;    // full product
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`INST_W-1:0]     inst_t;

    // which unit owns the instruction
    typedef enum logic [2:0] {
        OP_NONE,
        OP_ALU,
        OP_MUL,
        OP_DIV,
        OP_BRANCH
    } op_class_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU
    } br_op_e;

    typedef enum logic [1:0] {MUL_MUL, MUL_MULH, MUL_MULHSU, MUL_MULHU} mul_op_e;

    typedef enum logic [1:0] {DIV_DIV, DIV_DIVU, DIV_REM, DIV_REMU} div_op_e;

    typedef enum logic [1:0] {DIV_IDLE, DIV_RUN, DIV_DONE} div_state_e;

endpackage

// File: hdl/ex_decode.sv
// ################################################
// instruction decoder
// ################################################
`timescale 1ns/1ps
`include "ex_params.svh"

module ex_decode (
    input  ex_pkg::inst_t     inst_i,
    input  logic              valid_i,
    output ex_pkg::op_class_e class_o,
    output ex_pkg::alu_op_e   alu_op_o,
    output ex_pkg::br_op_e    br_op_o,
    output ex_pkg::mul_op_e   mul_op_o,
    output ex_pkg::div_op_e   div_op_o,
    output ex_pkg::reg_addr_t rd_o
);
    import ex_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign rd_o   = inst_i[11:7];
    assign alt    = inst_i[30];     // sub / sra select

    always_comb begin
        class_o  = OP_NONE;
        alu_op_o = ALU_ADD;
        br_op_o  = BR_EQ;
        mul_op_o = MUL_MUL;
        div_op_o = DIV_DIV;

        case (funct3)
            `F3_ADD_SUB: alu_op_o = (alt && opcode == `OPC_OP) ? ALU_SUB : ALU_ADD;
            `F3_SLL:     alu_op_o = ALU_SLL;
            `F3_SLT:     alu_op_o = ALU_SLT;
            `F3_SLTU:    alu_op_o = ALU_SLTU;
            `F3_XOR:     alu_op_o = ALU_XOR;
            `F3_SR:      alu_op_o = alt ? ALU_SRA : ALU_SRL;
            `F3_OR:      alu_op_o = ALU_OR;
            default:     alu_op_o = ALU_AND;
        endcase

        case (funct3)
            `F3_MUL:    mul_op_o = MUL_MUL;
            `F3_MULH:   mul_op_o = MUL_MULH;
            `F3_MULHSU: mul_op_o = MUL_MULHSU;
            default:    mul_op_o = MUL_MULHU;
        endcase

        case (funct3)
            `F3_DIV:  div_op_o = DIV_DIV;
            `F3_DIVU: div_op_o = DIV_DIVU;
            `F3_REM:  div_op_o = DIV_REM;
            default:  div_op_o = DIV_REMU;
        endcase

        case (funct3)
            `F3_BEQ:  br_op_o = BR_EQ;
            `F3_BNE:  br_op_o = BR_NE;
            `F3_BLT:  br_op_o = BR_LT;
            `F3_BGE:  br_op_o = BR_GE;
            `F3_BLTU: br_op_o = BR_LTU;
            default:  br_op_o = BR_GEU;
        endcase

        if (valid_i) begin
            case (opcode)
                `OPC_OP: begin
                    if (funct7 == `F7_MULDIV)
                        class_o = funct3[2] ? OP_DIV : OP_MUL;
                    else if (funct7 == `F7_BASE)
                        class_o = OP_ALU;
                    else if (funct7 == `F7_ALT && (funct3 == `F3_ADD_SUB || funct3 == `F3_SR))
                        class_o = OP_ALU;
                end
                `OPC_OP_IMM: begin
                    // shift immediates carry funct7 in the upper imm bits
                    if (funct3 == `F3_SLL)
                        class_o = (funct7 == `F7_BASE) ? OP_ALU : OP_NONE;
                    else if (funct3 == `F3_SR)
                        class_o = (funct7 == `F7_BASE || funct7 == `F7_ALT) ? OP_ALU : OP_NONE;
                    else
                        class_o = OP_ALU;
                end
                `OPC_BRANCH: begin
                    if (funct3 != 3'b010 && funct3 != 3'b011)
                        class_o = OP_BRANCH;
                end
                default: class_o = OP_NONE;
            endcase
        end
    end

endmodule

// File: hdl/ex_alu.sv
// ################################################
// integer alu and branch compare
// ################################################
`timescale 1ns/1ps
`include "ex_params.svh"

module ex_alu (
    input  ex_pkg::alu_op_e alu_op_i,
    input  ex_pkg::br_op_e  br_op_i,
    input  ex_pkg::word_t   op1_i,
    input  ex_pkg::word_t   op2_i,
    input  ex_pkg::word_t   reg1_rdata_i,
    input  ex_pkg::word_t   reg2_rdata_i,
    output ex_pkg::word_t   result_o,
    output logic            taken_o,
    output ex_pkg::word_t   target_o
);
    import ex_pkg::*;

    localparam int SHAMT_W = $clog2(`XLEN);

    logic [SHAMT_W-1:0] shamt;
    word_t              srl_res;
    word_t              sr_mask;
    word_t              sra_res;
    logic               lt_s;
    logic               lt_u;
    logic               eq;
    logic               ge_s;
    logic               ge_u;

    assign shamt   = op2_i[SHAMT_W-1:0];    // imm forms already hold shamt here
    assign srl_res = op1_i >> shamt;
    assign sr_mask = {`XLEN{1'b1}} >> shamt;
    // fill the vacated upper bits with the sign
    assign sra_res = (srl_res & sr_mask) | ({`XLEN{op1_i[`XLEN-1]}} & ~sr_mask);

    assign lt_s = $signed(op1_i) < $signed(op2_i);
    assign lt_u = op1_i < op2_i;

    always_comb begin
        case (alu_op_i)
            ALU_ADD:  result_o = op1_i + op2_i;
            ALU_SUB:  result_o = op1_i - op2_i;
            ALU_SLL:  result_o = op1_i << shamt;
            ALU_SLT:  result_o = {{(`XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: result_o = {{(`XLEN-1){1'b0}}, lt_u};
            ALU_XOR:  result_o = op1_i ^ op2_i;
            ALU_SRL:  result_o = srl_res;
            ALU_SRA:  result_o = sra_res;
            ALU_OR:   result_o = op1_i | op2_i;
            default:  result_o = op1_i & op2_i;
        endcase
    end

    // branch side compares the register values, not op1/op2
    assign eq   = reg1_rdata_i == reg2_rdata_i;
    assign ge_s = $signed(reg1_rdata_i) >= $signed(reg2_rdata_i);
    assign ge_u = reg1_rdata_i >= reg2_rdata_i;

    always_comb begin
        case (br_op_i)
            BR_EQ:   taken_o = eq;
            BR_NE:   taken_o = ~eq;
            BR_LT:   taken_o = ~ge_s;
            BR_GE:   taken_o = ge_s;
            BR_LTU:  taken_o = ~ge_u;
            default: taken_o = ge_u;
        endcase
    end

    assign target_o = op1_i + op2_i;    // pc + offset

endmodule

// File: hdl/ex_mul.sv
// ################################################
// single cycle multiplier
// ################################################
`timescale 1ns/1ps
`include "ex_params.svh"

module ex_mul (
    input  ex_pkg::mul_op_e mul_op_i,
    input  ex_pkg::word_t   op1_i,
    input  ex_pkg::word_t   op2_i,
    output ex_pkg::word_t   result_o
);
    import ex_pkg::*;

    logic   signed_a;
    logic   signed_b;
    logic   neg_a;
    logic   neg_b;
    word_t  mag_a;
    word_t  mag_b;
    dword_t prod;
    dword_t prod_fix;

    // mulhsu treats only op1 as signed
    assign signed_a = (mul_op_i == MUL_MULH) || (mul_op_i == MUL_MULHSU);
    assign signed_b = (mul_op_i == MUL_MULH);

    assign neg_a = signed_a && op1_i[`XLEN-1];
    assign neg_b = signed_b && op2_i[`XLEN-1];

    assign mag_a = neg_a ? (~op1_i + 1'b1) : op1_i;
    assign mag_b = neg_b ? (~op2_i + 1'b1) : op2_i;

    assign prod     = dword_t'(mag_a) * dword_t'(mag_b);
    assign prod_fix = (neg_a ^ neg_b) ? (~prod + 1'b1) : prod;

    always_comb begin
        if (mul_op_i == MUL_MUL)
            result_o = prod_fix[`XLEN-1:0];     // low word
        else
            result_o = prod_fix[2*`XLEN-1:`XLEN];
    end

endmodule

// File: hdl/ex_div.sv
// ################################################
// sequential restoring divider
// ################################################
`timescale 1ns/1ps
`include "ex_params.svh"

module ex_div (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              start_i,
    input  ex_pkg::div_op_e   div_op_i,
    input  ex_pkg::word_t     dividend_i,
    input  ex_pkg::word_t     divisor_i,
    input  ex_pkg::reg_addr_t rd_i,
    output logic              busy_o,
    output logic              done_o,
    output ex_pkg::word_t     result_o,
    output ex_pkg::reg_addr_t rd_o
);
    import ex_pkg::*;

    localparam int CNT_W = $clog2(`DIV_STEPS);

    div_state_e       state_q;
    logic [CNT_W-1:0] count_q;
    word_t            quot_q;
    word_t            rem_q;
    word_t            dvsr_q;
    logic             is_rem_q;
    logic             neg_quot_q;
    logic             neg_rem_q;
    logic             zero_q;
    logic             is_signed;
    word_t            mag_a;
    word_t            mag_b;
    logic [`XLEN:0]   trial;
    logic [`XLEN:0]   diff;
    logic             fits;
    word_t            quot_fix;
    word_t            rem_fix;

    assign is_signed = (div_op_i == DIV_DIV) || (div_op_i == DIV_REM);
    assign mag_a = (is_signed && dividend_i[`XLEN-1]) ? -dividend_i : dividend_i;
    assign mag_b = (is_signed && divisor_i[`XLEN-1]) ? -divisor_i : divisor_i;

    assign trial = {rem_q, quot_q[`XLEN-1]};    // shift next dividend bit in
    assign diff  = trial - {1'b0, dvsr_q};
    assign fits  = ~diff[`XLEN];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= DIV_IDLE;
            count_q <= '0;
        end else begin
            case (state_q)
                DIV_IDLE: begin
                    if (start_i)
                        state_q <= DIV_RUN;
                    count_q <= '0;
                end
                DIV_RUN: begin
                    count_q <= count_q + 1'b1;
                    if (count_q == CNT_W'(`DIV_STEPS - 1))
                        state_q <= DIV_DONE;
                end
                default: state_q <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == DIV_IDLE && start_i) begin
            quot_q     <= mag_a;
            rem_q      <= '0;
            dvsr_q     <= mag_b;
            is_rem_q   <= (div_op_i == DIV_REM) || (div_op_i == DIV_REMU);
            neg_quot_q <= is_signed && (dividend_i[`XLEN-1] ^ divisor_i[`XLEN-1]);
            neg_rem_q  <= is_signed && dividend_i[`XLEN-1];
            zero_q     <= (divisor_i == '0);
            rd_o       <= rd_i;
        end else if (state_q == DIV_RUN) begin
            quot_q <= {quot_q[`XLEN-2:0], fits};
            rem_q  <= fits ? diff[`XLEN-1:0] : trial[`XLEN-1:0];
        end
    end

    // remainder by zero comes out as |dividend|, the sign fix restores it
    // min / -1 needs no special case, the magnitude path gives min and 0
    assign quot_fix = zero_q ? '1 : (neg_quot_q ? -quot_q : quot_q);
    assign rem_fix  = neg_rem_q ? -rem_q : rem_q;
    assign result_o = is_rem_q ? rem_fix : quot_fix;

    assign busy_o = (state_q != DIV_IDLE);
    assign done_o = (state_q == DIV_DONE);

    // top must hold off new divides until the result is out
    a_no_start_busy: assert property (@(posedge clk_i) disable iff (reset_i)
        busy_o |-> !start_i);

    a_done_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
        done_o |=> !done_o);

endmodule

// File: hdl/ex_writeback.sv
// ################################################
// result select and output register
// ################################################
`timescale 1ns/1ps

module ex_writeback (
    input  logic              clk_i,
    input  logic              reset_i,
    input  ex_pkg::op_class_e class_i,
    input  ex_pkg::reg_addr_t rd_i,
    input  ex_pkg::word_t     alu_result_i,
    input  ex_pkg::word_t     mul_result_i,
    input  ex_pkg::word_t     target_i,
    input  ex_pkg::word_t     div_result_i,
    input  logic              taken_i,
    input  logic              div_done_i,
    input  ex_pkg::reg_addr_t div_rd_i,
    output logic              reg_we_o,
    output ex_pkg::reg_addr_t reg_waddr_o,
    output ex_pkg::word_t     reg_wdata_o,
    output logic              jump_flag_o,
    output ex_pkg::word_t     jump_addr_o
);
    import ex_pkg::*;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            reg_we_o    <= 1'b0;
            jump_flag_o <= 1'b0;
        end else begin
            reg_we_o    <= div_done_i || (class_i == OP_ALU) || (class_i == OP_MUL);
            jump_flag_o <= !div_done_i && (class_i == OP_BRANCH) && taken_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (div_done_i) begin   // no accept can coincide, source is held off
            reg_waddr_o <= div_rd_i;
            reg_wdata_o <= div_result_i;
        end else begin
            reg_waddr_o <= rd_i;
            reg_wdata_o <= (class_i == OP_MUL) ? mul_result_i : alu_result_i;
        end
        if (class_i == OP_BRANCH)
            jump_addr_o <= taken_i ? target_i : '0;     // zero when not taken
    end

    a_we_jump_excl: assert property (@(posedge clk_i) disable iff (reset_i)
        !(reg_we_o && jump_flag_o));

endmodule

// File: hdl/ex_top.sv
// ################################################
// execute stage top
// ################################################
`timescale 1ns/1ps

module ex_top (
    input  logic              clk_i,
    input  logic              reset_i,
    input  ex_pkg::inst_t     inst_i,
    input  ex_pkg::word_t     inst_addr_i,
    input  ex_pkg::word_t     op1_i,
    input  ex_pkg::word_t     op2_i,
    input  ex_pkg::word_t     reg1_rdata_i,
    input  ex_pkg::word_t     reg2_rdata_i,
    input  logic              valid_i,
    output logic              ready_o,
    output logic              reg_we_o,
    output ex_pkg::reg_addr_t reg_waddr_o,
    output ex_pkg::word_t     reg_wdata_o,
    output logic              jump_flag_o,
    output ex_pkg::word_t     jump_addr_o
);
    import ex_pkg::*;

    logic      accept;
    logic      div_busy;
    logic      div_done;
    op_class_e op_class;
    alu_op_e   alu_op;
    br_op_e    br_op;
    mul_op_e   mul_op;
    div_op_e   div_op;
    reg_addr_t rd;
    reg_addr_t div_rd;
    word_t     alu_result;
    word_t     mul_result;
    word_t     div_result;
    word_t     target;
    logic      taken;

    assign ready_o = ~div_busy;
    assign accept  = valid_i & ready_o;     // class stays OP_NONE unless accepted

    ex_decode u_decode (
        .inst_i  (inst_i),
        .valid_i (accept),
        .class_o (op_class),
        .alu_op_o(alu_op),
        .br_op_o (br_op),
        .mul_op_o(mul_op),
        .div_op_o(div_op),
        .rd_o    (rd)
    );

    ex_alu u_alu (
        .alu_op_i    (alu_op),
        .br_op_i     (br_op),
        .op1_i       (op1_i),
        .op2_i       (op2_i),
        .reg1_rdata_i(reg1_rdata_i),
        .reg2_rdata_i(reg2_rdata_i),
        .result_o    (alu_result),
        .taken_o     (taken),
        .target_o    (target)
    );

    ex_mul u_mul (
        .mul_op_i(mul_op),
        .op1_i   (op1_i),
        .op2_i   (op2_i),
        .result_o(mul_result)
    );

    ex_div u_div (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .start_i   (op_class == OP_DIV),
        .div_op_i  (div_op),
        .dividend_i(op1_i),
        .divisor_i (op2_i),
        .rd_i      (rd),
        .busy_o    (div_busy),
        .done_o    (div_done),
        .result_o  (div_result),
        .rd_o      (div_rd)
    );

    ex_writeback u_writeback (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .class_i     (op_class),
        .rd_i        (rd),
        .alu_result_i(alu_result),
        .mul_result_i(mul_result),
        .target_i    (target),
        .div_result_i(div_result),
        .taken_i     (taken),
        .div_done_i  (div_done),
        .div_rd_i    (div_rd),
        .reg_we_o    (reg_we_o),
        .reg_waddr_o (reg_waddr_o),
        .reg_wdata_o (reg_wdata_o),
        .jump_flag_o (jump_flag_o),
        .jump_addr_o (jump_addr_o)
    );

    // decode stage hands a branch its own pc as op1
    a_branch_pc: assert property (@(posedge clk_i) disable iff (reset_i)
        (op_class == OP_BRANCH) |-> (op1_i == inst_addr_i));

endmodule

// File: testbench/tb_ex_ref.svh
// ##################################################
// execute stage reference model
// ##################################################
`ifndef TB_EX_REF_SVH
`define TB_EX_REF_SVH

`include "ex_params.svh"

typedef struct packed {
    logic        is_div;
    logic        we;
    logic [4:0]  rd;
    logic [31:0] data;
    logic        jump;
    logic [31:0] jaddr;
} exp_t;

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, `OPC_OP};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [4:0] rs1);
    return {imm, rs1, f3, rd, `OPC_OP_IMM};
endfunction

// b-type scatters the offset bits
function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [2:0] f3,
                                      input logic [4:0] rs1, input logic [4:0] rs2);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OPC_BRANCH};
endfunction

function automatic logic [31:0] alu_ref(input logic [6:0] opc, input logic [2:0] f3,
                                        input logic alt, input logic [31:0] a,
                                        input logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (f3)
        `F3_ADD_SUB: return (opc == `OPC_OP && alt) ? a - b : a + b;
        `F3_SLL:     return a << sh;
        `F3_SLT:     return {31'd0, $signed(a) < $signed(b)};
        `F3_SLTU:    return {31'd0, a < b};
        `F3_XOR:     return a ^ b;
        `F3_SR: begin
            if (alt)
                return $signed(a) >>> sh;
            else
                return a >> sh;
        end
        `F3_OR:      return a | b;
        default:     return a & b;
    endcase
endfunction

// sign extend to 64 bits, keep the low 64 of the product
function automatic logic [31:0] mul_ref(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    logic        sa;
    logic        sb;
    logic [63:0] a64;
    logic [63:0] b64;
    logic [63:0] p;
    sa  = (f3 == `F3_MULH) || (f3 == `F3_MULHSU);
    sb  = (f3 == `F3_MULH);
    a64 = {{32{sa & a[31]}}, a};
    b64 = {{32{sb & b[31]}}, b};
    p   = a64 * b64;
    return (f3 == `F3_MUL) ? p[31:0] : p[63:32];
endfunction

function automatic logic [31:0] div_ref(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    logic ovf;
    ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (f3)
        `F3_DIV: begin
            if (b == 32'd0)
                return 32'hffff_ffff;
            else if (ovf)
                return 32'h8000_0000;
            else
                return $signed(a) / $signed(b);
        end
        `F3_DIVU: return (b == 32'd0) ? 32'hffff_ffff : a / b;
        `F3_REM: begin
            if (b == 32'd0)
                return a;
            else if (ovf)
                return 32'd0;
            else
                return $signed(a) % $signed(b);
        end
        default: return (b == 32'd0) ? a : a % b;
    endcase
endfunction

function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                    input logic [31:0] b);
    case (f3)
        `F3_BEQ:  return a == b;
        `F3_BNE:  return a != b;
        `F3_BLT:  return $signed(a) < $signed(b);
        `F3_BGE:  return $signed(a) >= $signed(b);
        `F3_BLTU: return a < b;
        default:  return a >= b;
    endcase
endfunction

function automatic exp_t ref_exec(input logic [31:0] inst, input logic [31:0] op1,
                                  input logic [31:0] op2, input logic [31:0] r1,
                                  input logic [31:0] r2);
    exp_t       e;
    logic [6:0] opc;
    logic [2:0] f3;
    e   = '0;
    opc = inst[6:0];
    f3  = inst[14:12];
    e.rd = inst[11:7];
    if (opc == `OPC_BRANCH) begin
        e.jump  = branch_ref(f3, r1, r2);
        e.jaddr = op1 + op2;            // pc + offset
    end else if (opc == `OPC_OP && inst[31:25] == `F7_MULDIV) begin
        e.we     = 1'b1;
        e.is_div = f3[2];
        e.data   = f3[2] ? div_ref(f3, op1, op2) : mul_ref(f3, op1, op2);
    end else begin
        e.we   = 1'b1;
        e.data = alu_ref(opc, f3, inst[30], op1, op2);
    end
    return e;
endfunction

`endif

// File: testbench/tb_ex.sv
// ##################################################
// execute stage testbench
// ##################################################
`timescale 1ns/1ps
`include "ex_params.svh"

module tb_ex;
    import ex_pkg::*;

    `include "tb_ex_ref.svh"

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int N_ALU        = 40;
    localparam int N_MUL        = 28;   // 4 forms with 4 random and 3 corner pairs each
    localparam int N_BR         = 24;
    localparam int N_DIV        = 28;
    localparam int N_TESTS      = N_ALU + N_MUL + N_BR + N_DIV + 1;

    logic        clk_i;
    logic        reset_i;
    logic [31:0] inst_i;
    logic [31:0] inst_addr_i;
    logic [31:0] op1_i;
    logic [31:0] op2_i;
    logic [31:0] reg1_rdata_i;
    logic [31:0] reg2_rdata_i;
    logic        valid_i;
    logic        ready_o;
    logic        reg_we_o;
    logic [4:0]  reg_waddr_o;
    logic [31:0] reg_wdata_o;
    logic        jump_flag_o;
    logic [31:0] jump_addr_o;

    exp_t   exp_q[$];
    integer seed;

    ex_top UUT (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .inst_i      (inst_i),
        .inst_addr_i (inst_addr_i),
        .op1_i       (op1_i),
        .op2_i       (op2_i),
        .reg1_rdata_i(reg1_rdata_i),
        .reg2_rdata_i(reg2_rdata_i),
        .valid_i     (valid_i),
        .ready_o     (ready_o),
        .reg_we_o    (reg_we_o),
        .reg_waddr_o (reg_waddr_o),
        .reg_wdata_o (reg_wdata_o),
        .jump_flag_o (jump_flag_o),
        .jump_addr_o (jump_addr_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s = 0x%08h, expected 0x%08h",
                     $time, name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // holds the instruction until ready_o and queues the expectation at the accepting edge
    task automatic issue(input logic [31:0] inst, input logic [31:0] a, input logic [31:0] b,
                         input logic [31:0] r1, input logic [31:0] r2, input logic [31:0] pc);
        @(negedge clk_i);
        inst_i       = inst;
        op1_i        = a;
        op2_i        = b;
        reg1_rdata_i = r1;
        reg2_rdata_i = r2;
        inst_addr_i  = pc;
        valid_i      = 1'b1;
        while (!ready_o)
            @(negedge clk_i);
        @(posedge clk_i);
        exp_q.push_back(ref_exec(inst, a, b, r1, r2));
    endtask

    task automatic alu_tests();
        logic [31:0] sel;
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        for (int i = 0; i < N_ALU; i++) begin
            sel = $random(seed);
            a   = $random(seed);
            b   = $random(seed);
            f3  = sel[2:0];
            if (i % 2 == 0) begin   // register form
                f7 = ((f3 == `F3_ADD_SUB || f3 == `F3_SR) && sel[3]) ? `F7_ALT : `F7_BASE;
                issue(enc_r(f7, f3, sel[16:12], sel[21:17], sel[26:22]), a, b, 0, 0, 0);
            end else begin
                imm = sel[31:20];
                if (f3 == `F3_SLL)
                    imm[11:5] = `F7_BASE;
                else if (f3 == `F3_SR)
                    imm[11:5] = sel[3] ? `F7_ALT : `F7_BASE;
                b = {{20{imm[11]}}, imm};
                issue(enc_i(imm, f3, sel[16:12], sel[21:17]), a, b, 0, 0, 0);
            end
        end
    endtask

    task automatic mul_tests();
        logic [31:0] sel;
        logic [31:0] a;
        logic [31:0] b;
        for (int f = 0; f < 4; f++) begin
            for (int i = 0; i < 7; i++) begin
                sel = $random(seed);
                case (i)
                    4: begin
                        a = 32'h8000_0000;
                        b = 32'hffff_ffff;
                    end
                    5: begin
                        a = 32'hffff_ffff;
                        b = 32'hffff_ffff;
                    end
                    6: begin
                        a = 32'h8000_0000;
                        b = 32'h8000_0000;
                    end
                    default: begin
                        a = $random(seed);
                        b = $random(seed);
                    end
                endcase
                issue(enc_r(`F7_MULDIV, 3'(f), sel[4:0], sel[9:5], sel[14:10]), a, b, 0, 0, 0);
            end
        end
    endtask

    task automatic branch_tests();
        logic [31:0] sel;
        logic [31:0] x;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] pc;
        logic [12:0] off;
        logic [2:0]  f3;
        for (int k = 0; k < 6; k++) begin
            f3 = (k < 2) ? 3'(k) : 3'(k + 2);   // skip the two unused codes
            for (int p = 0; p < 4; p++) begin
                sel = $random(seed);
                x   = sel & 32'h3fff_ffff;
                pc  = $random(seed);
                pc[1:0] = 2'b00;
                off = {sel[12:1], 1'b0};
                case (p)
                    0: begin
                        r1 = x;
                        r2 = x;
                    end
                    1: begin
                        r1 = x;
                        r2 = x + 32'd5;
                    end
                    2: begin
                        r1 = x + 32'd5;
                        r2 = x;
                    end
                    default: begin
                        r1 = x | 32'h8000_0000;     // signs disagree
                        r2 = x;
                    end
                endcase
                issue(enc_b(off, f3, sel[20:16], sel[25:21]), pc, {{19{off[12]}}, off},
                      r1, r2, pc);
            end
        end
    endtask

    task automatic div_tests();
        logic [31:0] sel;
        logic [31:0] a;
        logic [31:0] b;
        for (int f = 0; f < 4; f++) begin
            for (int i = 0; i < 7; i++) begin
                sel = $random(seed);
                a   = $random(seed);
                b   = $random(seed);
                b   = b >> sel[19:15];   // spread the divisor sizes
                if (i == 5) begin
                    b = 32'd0;
                end else if (i == 6) begin
                    a = 32'h8000_0000;
                    b = 32'hffff_ffff;
                end
                issue(enc_r(`F7_MULDIV, 3'(4 + f), sel[4:0], sel[9:5], sel[14:10]), a, b,
                      0, 0, 0);
            end
        end
    endtask

    // compares at the falling edge where the registered outputs are settled
    initial begin : compare
        exp_t e;
        @(negedge reset_i);
        forever begin
            @(negedge clk_i);
            if (exp_q.size() == 0) begin
                check("reg_we_o", 32'(reg_we_o), 32'd0);
                check("jump_flag_o", 32'(jump_flag_o), 32'd0);
                check("ready_o", 32'(ready_o), 32'd1);
            end else if (!exp_q[0].is_div || reg_we_o) begin
                e = exp_q.pop_front();
                check("reg_we_o", 32'(reg_we_o), 32'(e.we));
                if (e.we) begin
                    check("reg_waddr_o", 32'(reg_waddr_o), 32'(e.rd));
                    check("reg_wdata_o", reg_wdata_o, e.data);
                end
                check("jump_flag_o", 32'(jump_flag_o), 32'(e.jump));
                if (e.jump)
                    check("jump_addr_o", jump_addr_o, e.jaddr);
                check("ready_o", 32'(ready_o), 32'd1);
            end else begin
                check("ready_o", 32'(ready_o), 32'd0);   // divider still busy
                check("jump_flag_o", 32'(jump_flag_o), 32'd0);
            end
        end
    end

    initial begin : watchdog
        repeat (RESET_CYCLES + N_TESTS * (`DIV_STEPS + 4)) @(posedge clk_i);
        $display("SIMULATION FAILED");
        $fatal(1, "timeout: the tests did not complete in the allowed number of cycles");
    end

    initial begin : stimulus
        seed         = 32'h8afb_ce10;
        reset_i      = 1'b1;
        valid_i      = 1'b0;
        inst_i       = 32'd0;
        inst_addr_i  = 32'd0;
        op1_i        = 32'd0;
        op2_i        = 32'd0;
        reg1_rdata_i = 32'd0;
        reg2_rdata_i = 32'd0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        check("ready_o", 32'(ready_o), 32'd1);
        check("reg_we_o", 32'(reg_we_o), 32'd0);
        check("jump_flag_o", 32'(jump_flag_o), 32'd0);

        alu_tests();
        mul_tests();
        branch_tests();
        div_tests();
        // held behind the last divide
        issue(enc_r(`F7_BASE, `F3_ADD_SUB, 5'd7, 5'd1, 5'd2), 32'd100, 32'd23, 0, 0, 0);
        @(negedge clk_i);
        valid_i = 1'b0;

        while (exp_q.size() != 0)
            @(posedge clk_i);
        repeat (2) @(negedge clk_i);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: list.f
+incdir+hdl
+incdir+testbench
hdl/ex_pkg.sv
hdl/ex_decode.sv
hdl/ex_alu.sv
hdl/ex_mul.sv
hdl/ex_div.sv
hdl/ex_writeback.sv
hdl/ex_top.sv
testbench/tb_ex.sv

// File: Makefile
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_ex
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, exit status gives pass or fail"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
